/* mmem_defines.svh */
// ############################
// Width and depth macros for
// the scratchpad unit.
// ############################

`ifndef MMEM_DEFINES_SVH
`define MMEM_DEFINES_SVH

// Word address, 32 words.
`define MMEM_AW 5

// Data word width.
`define MMEM_DW 32

// External opcode field width.
`define MMEM_OPW 3

// Micro-op slots, also the reset credit count.
`define MMEM_FIFO_DEPTH 4

`endif

/* mmem_dpram.sv */
// ############################
// 32x32 dual-port RAM with
// registered read data.
// ############################

`include "mmem_defines.svh"

module mmem_dpram
(
   input  logic               clk_a,
   input  logic               reset,
   input  logic [`MMEM_AW-1:0] address_a,
   input  logic [`MMEM_DW-1:0] data_a,
   input  logic               wren_a,
   input  logic               rden_a,
   output logic [`MMEM_DW-1:0] q_a,
   input  logic [`MMEM_AW-1:0] address_b,
   input  logic [`MMEM_DW-1:0] data_b,
   input  logic               wren_b,
   input  logic               rden_b,
   output logic [`MMEM_DW-1:0] q_b
);

   localparam int RAM_SIZE = 1 << `MMEM_AW;

   logic [`MMEM_DW-1:0] ram [0:RAM_SIZE-1];

   // Single write per cycle, port a wins.
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         ram[address_a] <= data_a;
      end
      else if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= ram[address_a];  // Old data on a same-port write.
      end
   end

   // Port b shares clk_a.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= ram[address_b];
      end
   end

endmodule

/* mmem_exec.sv */
// ############################
// Executor FSM, ALU and
// write-back.
// ############################

`include "mmem_defines.svh"

module mmem_exec
   import mmem_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                empty,
   input  mmem_op_e            head_op,
   input  logic [`MMEM_AW-1:0] head_dst,
   input  logic [`MMEM_AW-1:0] head_srca,
   input  logic [`MMEM_AW-1:0] head_srcb,
   input  logic [`MMEM_DW-1:0] head_imm,
   output logic                pop,
   output logic [`MMEM_AW-1:0] address_a,
   output logic [`MMEM_AW-1:0] address_b,
   output logic [`MMEM_DW-1:0] data_a,
   output logic                wren_a,
   output logic                rden_a,
   output logic                rden_b,
   input  logic [`MMEM_DW-1:0] q_a,
   input  logic [`MMEM_DW-1:0] q_b,
   output logic                result_valid,
   output logic [`MMEM_AW-1:0] result_addr,
   output logic [`MMEM_DW-1:0] result_data
);

   mmem_exec_state_e    state;
   mmem_op_e            op_q;
   logic [`MMEM_AW-1:0] dst_q;
   logic [`MMEM_AW-1:0] srca_q;
   logic [`MMEM_AW-1:0] srcb_q;
   logic [`MMEM_DW-1:0] imm_q;
   logic [`MMEM_DW-1:0] alu;

   assign pop = (state == EX_IDLE) & ~empty;

   // Port a reads srca, then carries the write-back.
   assign rden_a = (state == EX_READ);
   assign rden_b = (state == EX_READ);
   assign wren_a = (state == EX_WRITE);
   assign address_a = (state == EX_WRITE) ? dst_q : srca_q;
   assign address_b = srcb_q;
   assign data_a = alu;

   // Operands are valid in EX_WRITE.
   always_comb
   begin
      case (op_q)
         OP_LOAD: alu = imm_q;
         OP_ADD:  alu = q_a + q_b;
         OP_SUB:  alu = q_a - q_b;  // Wraps mod 2^32.
         OP_AND:  alu = q_a & q_b;
         OP_OR:   alu = q_a | q_b;
         OP_XOR:  alu = q_a ^ q_b;
         default: alu = '0;
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= EX_IDLE;
      end
      else
      begin
         case (state)
            EX_IDLE:  state <= pop ? EX_READ : EX_IDLE;
            EX_READ:  state <= EX_WRITE;
            EX_WRITE: state <= EX_IDLE;
            default:  state <= EX_IDLE;
         endcase
      end
   end

   // Micro-op held for the read and write cycles.
   always_ff @(posedge clk_a)
   begin
      if (pop)
      begin
         op_q <= head_op;
         dst_q <= head_dst;
         srca_q <= head_srca;
         srcb_q <= head_srcb;
         imm_q <= head_imm;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         result_valid <= 1'b0;
      end
      else
      begin
         result_valid <= (state == EX_WRITE);
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (state == EX_WRITE)
      begin
         result_addr <= dst_q;
         result_data <= alu;
      end
   end

endmodule

/* mmem_issue.sv */
// ############################
// Issue stage: decode, credit
// counter, illegal flag.
// ############################

`include "mmem_defines.svh"

module mmem_issue
   import mmem_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  instr_valid,
   input  logic [`MMEM_OPW-1:0]  instr_op,
   input  logic [`MMEM_AW-1:0]   instr_dst,
   input  logic [`MMEM_AW-1:0]   instr_srca,
   input  logic [`MMEM_AW-1:0]   instr_srcb,
   input  logic [`MMEM_DW-1:0]   instr_imm,
   output logic                  instr_ready,
   output logic                  push,
   output mmem_op_e              uop_op,
   output logic [`MMEM_AW-1:0]   uop_dst,
   output logic [`MMEM_AW-1:0]   uop_srca,
   output logic [`MMEM_AW-1:0]   uop_srcb,
   output logic [`MMEM_DW-1:0]   uop_imm,
   input  logic                  credit_return,
   output logic                  illegal_op
);

   localparam int CW = $clog2(`MMEM_FIFO_DEPTH + 1);

   logic [CW-1:0] credits;
   logic          op_legal;
   logic          take;

   // Anything above OP_XOR is illegal.
   assign op_legal = (instr_op <= OP_XOR);

   assign instr_ready = (credits != '0);
   assign take = instr_valid & instr_ready;

   // Same-edge push, no staging register.
   assign push = take & op_legal;
   assign uop_op = mmem_op_e'(instr_op);
   assign uop_dst = instr_dst;
   assign uop_srca = instr_srca;
   assign uop_srcb = instr_srcb;
   assign uop_imm = instr_imm;

   // One credit per push, one back per FIFO pop.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         credits <= CW'(`MMEM_FIFO_DEPTH);
      end
      else
      begin
         credits <= credits - CW'(push) + CW'(credit_return);
      end
   end

   // Dropped instruction, flagged one cycle later.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         illegal_op <= 1'b0;
      end
      else
      begin
         illegal_op <= take & ~op_legal;
      end
   end

endmodule

/* mmem_pkg.sv */
// ############################
// Opcode and executor state
// enums.
// ############################

`include "mmem_defines.svh"

package mmem_pkg;

   // Codes 6 and 7 are illegal and never reach the FIFO.
   typedef enum logic [`MMEM_OPW-1:0]
   {
      OP_LOAD = 3'd0,  // dst <= imm.
      OP_ADD  = 3'd1,
      OP_SUB  = 3'd2,  // srca - srcb, wraps.
      OP_AND  = 3'd3,
      OP_OR   = 3'd4,
      OP_XOR  = 3'd5
   } mmem_op_e;

   // Executor FSM, three cycles per micro-op.
   typedef enum logic [1:0]
   {
      EX_IDLE  = 2'd0,  // Pop when FIFO not empty.
      EX_READ  = 2'd1,  // Operand addresses on both ports.
      EX_WRITE = 2'd2   // ALU result back through port a.
   } mmem_exec_state_e;

endpackage

/* mmem_unit.sv */
// ############################
// Scratchpad execution unit
// top level.
// ############################

`include "mmem_defines.svh"

module mmem_unit
   import mmem_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                instr_valid,
   input  logic [`MMEM_OPW-1:0] instr_op,
   input  logic [`MMEM_AW-1:0] instr_dst,
   input  logic [`MMEM_AW-1:0] instr_srca,
   input  logic [`MMEM_AW-1:0] instr_srcb,
   input  logic [`MMEM_DW-1:0] instr_imm,
   output logic                instr_ready,
   output logic                result_valid,
   output logic [`MMEM_AW-1:0] result_addr,
   output logic [`MMEM_DW-1:0] result_data,
   output logic                illegal_op
);

   logic                push;
   mmem_op_e            uop_op;
   logic [`MMEM_AW-1:0] uop_dst;
   logic [`MMEM_AW-1:0] uop_srca;
   logic [`MMEM_AW-1:0] uop_srcb;
   logic [`MMEM_DW-1:0] uop_imm;
   logic                credit_return;
   logic                pop;
   logic                empty;
   mmem_op_e            head_op;
   logic [`MMEM_AW-1:0] head_dst;
   logic [`MMEM_AW-1:0] head_srca;
   logic [`MMEM_AW-1:0] head_srcb;
   logic [`MMEM_DW-1:0] head_imm;
   logic [`MMEM_AW-1:0] address_a;
   logic [`MMEM_AW-1:0] address_b;
   logic [`MMEM_DW-1:0] data_a;
   logic                wren_a;
   logic                rden_a;
   logic                rden_b;
   logic [`MMEM_DW-1:0] q_a;
   logic [`MMEM_DW-1:0] q_b;

   mmem_issue u_issue (
      .clk_a, .reset, .instr_valid, .instr_op, .instr_dst, .instr_srca,
      .instr_srcb, .instr_imm, .instr_ready, .push, .uop_op, .uop_dst,
      .uop_srca, .uop_srcb, .uop_imm, .credit_return, .illegal_op
   );

   mmem_uop_fifo u_fifo (
      .clk_a, .reset, .push, .uop_op, .uop_dst, .uop_srca, .uop_srcb,
      .uop_imm, .pop, .empty, .head_op, .head_dst, .head_srca,
      .head_srcb, .head_imm, .credit_return
   );

   mmem_exec u_exec (
      .clk_a, .reset, .empty, .head_op, .head_dst, .head_srca, .head_srcb,
      .head_imm, .pop, .address_a, .address_b, .data_a, .wren_a, .rden_a,
      .rden_b, .q_a, .q_b, .result_valid, .result_addr, .result_data
   );

   // Port b is read-only here.
   mmem_dpram u_ram (
      .clk_a, .reset, .address_a, .data_a, .wren_a, .rden_a, .q_a,
      .address_b, .data_b ('0), .wren_b (1'b0), .rden_b, .q_b
   );

endmodule

/* mmem_uop_fifo.sv */
// ############################
// Micro-op FIFO with credit
// return on pop.
// ############################

`include "mmem_defines.svh"

module mmem_uop_fifo
   import mmem_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                push,
   input  mmem_op_e            uop_op,
   input  logic [`MMEM_AW-1:0] uop_dst,
   input  logic [`MMEM_AW-1:0] uop_srca,
   input  logic [`MMEM_AW-1:0] uop_srcb,
   input  logic [`MMEM_DW-1:0] uop_imm,
   input  logic                pop,
   output logic                empty,
   output mmem_op_e            head_op,
   output logic [`MMEM_AW-1:0] head_dst,
   output logic [`MMEM_AW-1:0] head_srca,
   output logic [`MMEM_AW-1:0] head_srcb,
   output logic [`MMEM_DW-1:0] head_imm,
   output logic                credit_return
);

   localparam int DEPTH = `MMEM_FIFO_DEPTH;
   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   mmem_op_e            op_mem   [0:DEPTH-1];
   logic [`MMEM_AW-1:0] dst_mem  [0:DEPTH-1];
   logic [`MMEM_AW-1:0] srca_mem [0:DEPTH-1];
   logic [`MMEM_AW-1:0] srcb_mem [0:DEPTH-1];
   logic [`MMEM_DW-1:0] imm_mem  [0:DEPTH-1];

   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_pop;

   assign empty = (count == '0);
   assign do_pop = pop & ~empty;

   assign head_op = op_mem[rd_ptr];
   assign head_dst = dst_mem[rd_ptr];
   assign head_srca = srca_mem[rd_ptr];
   assign head_srcb = srcb_mem[rd_ptr];
   assign head_imm = imm_mem[rd_ptr];

   // Credits upstream keep this from overflowing.
   always_ff @(posedge clk_a)
   begin
      if (push)
      begin
         op_mem[wr_ptr] <= uop_op;
         dst_mem[wr_ptr] <= uop_dst;
         srca_mem[wr_ptr] <= uop_srca;
         srcb_mem[wr_ptr] <= uop_srcb;
         imm_mem[wr_ptr] <= uop_imm;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         credit_return <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CW'(push) - CW'(do_pop);
         credit_return <= do_pop;  // One slot freed.
      end
   end

endmodule

/* tb.f */
+incdir+.
mmem_pkg.sv
mmem_dpram.sv
mmem_issue.sv
mmem_uop_fifo.sv
mmem_exec.sv
mmem_unit.sv
tb_mmem_unit.sv

/* tb_mmem_unit.sv */
// ##############################
// Testbench for the scratchpad
// unit with a memory model.
// ##############################

`include "mmem_defines.svh"

module tb_mmem_unit
   import mmem_pkg::*;
();

   logic                 clk_a;
   logic                 reset;
   logic                 instr_valid;
   logic [`MMEM_OPW-1:0] instr_op;
   logic [`MMEM_AW-1:0]  instr_dst;
   logic [`MMEM_AW-1:0]  instr_srca;
   logic [`MMEM_AW-1:0]  instr_srcb;
   logic [`MMEM_DW-1:0]  instr_imm;
   logic                 instr_ready;
   logic                 result_valid;
   logic [`MMEM_AW-1:0]  result_addr;
   logic [`MMEM_DW-1:0]  result_data;
   logic                 illegal_op;

   // Stimulus table, one entry per instruction.
   string                name_t [$];
   logic [`MMEM_OPW-1:0] op_t [$];
   logic [`MMEM_AW-1:0]  dst_t [$];
   logic [`MMEM_AW-1:0]  srca_t [$];
   logic [`MMEM_AW-1:0]  srcb_t [$];
   logic [`MMEM_DW-1:0]  imm_t [$];
   bit                   rnd_t [$];   // Random immediate.
   bit                   gap_t [$];   // Random idle cycles before.
   bit                   rst_t [$];   // Reset while busy before.

   logic [`MMEM_DW-1:0]  model_mem [0:(1 << `MMEM_AW)-1];
   string                exp_name_q [$];
   logic [`MMEM_AW-1:0]  exp_addr_q [$];
   logic [`MMEM_DW-1:0]  exp_data_q [$];
   int                   illegal_exp = 0;
   int                   illegal_seen = 0;
   logic                 ready_dropped = 1'b0;
   int                   table_len = 0;
   int unsigned          seed;

   mmem_unit u_mmem_unit (
      .clk_a, .reset, .instr_valid, .instr_op, .instr_dst, .instr_srca, .instr_srcb,
      .instr_imm, .instr_ready, .result_valid, .result_addr, .result_data, .illegal_op
   );

   initial
   begin
      clk_a = 1'b0;
      forever #50 clk_a = ~clk_a;
   end

   task automatic check_result(input string name, input logic [`MMEM_AW-1:0] exp_addr,
                               input logic [`MMEM_DW-1:0] exp_data,
                               input logic [`MMEM_AW-1:0] act_addr,
                               input logic [`MMEM_DW-1:0] act_data);
      if (act_addr !== exp_addr || act_data !== exp_data)
      begin
         $display("FAILED %s: expected addr %0d data %h, actual addr %0d data %h",
                  name, exp_addr, exp_data, act_addr, act_data);
         $display("TEST FAILED");
         $fatal(1, "result mismatch");
      end
   endtask

   task automatic check_illegal(input string name, input int exp_count, input int act_count);
      if (act_count != exp_count)
      begin
         $display("FAILED %s: expected %0d illegal pulses, actual %0d",
                  name, exp_count, act_count);
         $display("TEST FAILED");
         $fatal(1, "illegal count mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val)
      begin
         $display("FAILED %s: expected %b, actual %b", name, exp_val, act_val);
         $display("TEST FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   function automatic logic [`MMEM_DW-1:0] expected_value(input logic [`MMEM_OPW-1:0] op,
      input logic [`MMEM_DW-1:0] a, input logic [`MMEM_DW-1:0] b,
      input logic [`MMEM_DW-1:0] imm);
      case (op)
         OP_LOAD: return imm;
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;  // Modulo 2^32.
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         default: return a ^ b;
      endcase
   endfunction

   task automatic add_entry(input string name, input logic [`MMEM_OPW-1:0] op,
                            input int dst, input int srca, input int srcb,
                            input logic [`MMEM_DW-1:0] imm, input bit rnd, input bit gap,
                            input bit rst);
      name_t.push_back(name);
      op_t.push_back(op);
      dst_t.push_back(dst[`MMEM_AW-1:0]);
      srca_t.push_back(srca[`MMEM_AW-1:0]);
      srcb_t.push_back(srcb[`MMEM_AW-1:0]);
      imm_t.push_back(imm);
      rnd_t.push_back(rnd);
      gap_t.push_back(gap);
      rst_t.push_back(rst);
   endtask

   // Issue order equals execution order.
   task automatic model_issue(input int i, input logic [`MMEM_DW-1:0] imm);
      logic [`MMEM_DW-1:0] data;
      if (op_t[i] > OP_XOR)
      begin
         illegal_exp++;
      end
      else
      begin
         data = expected_value(op_t[i], model_mem[srca_t[i]], model_mem[srcb_t[i]], imm);
         model_mem[dst_t[i]] = data;
         exp_name_q.push_back(name_t[i]);
         exp_addr_q.push_back(dst_t[i]);
         exp_data_q.push_back(data);
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (8) @(negedge clk_a);
      reset = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_addr_q.size() != 0) @(negedge clk_a);
      repeat (2) @(negedge clk_a);  // Let a late illegal pulse land.
   endtask

   // Self-ORs of one word leave memory unchanged whether or not they finish.
   task automatic reset_while_busy(input logic [`MMEM_AW-1:0] addr);
      int n;
      n = 0;
      instr_op = OP_OR;
      instr_dst = addr;
      instr_srca = addr;
      instr_srcb = addr;
      instr_imm = '0;
      instr_valid = 1'b1;
      while (instr_ready === 1'b1 && n < 2 * `MMEM_FIFO_DEPTH)
      begin
         @(posedge clk_a);
         exp_name_q.push_back("reset_busy");
         exp_addr_q.push_back(addr);
         exp_data_q.push_back(model_mem[addr]);
         n++;
         @(negedge clk_a);
      end
      instr_valid = 1'b0;
      check_flag("busy_before_reset", 1'b0, instr_ready);
      apply_reset();
      exp_name_q.delete();  // Pending results are lost.
      exp_addr_q.delete();
      exp_data_q.delete();
      check_flag("ready_after_reset", 1'b1, instr_ready);
      check_flag("no_result_after_reset", 1'b0, result_valid);
   endtask

   task automatic run_entry(input int i);
      logic [`MMEM_DW-1:0] imm;
      if (rst_t[i])
      begin
         wait_drain();
         reset_while_busy(dst_t[i]);
      end
      if (gap_t[i])
      begin
         instr_valid = 1'b0;
         repeat ($urandom_range(2)) @(negedge clk_a);
      end
      imm = rnd_t[i] ? $urandom : imm_t[i];
      instr_op = op_t[i];
      instr_dst = dst_t[i];
      instr_srca = srca_t[i];
      instr_srcb = srcb_t[i];
      instr_imm = imm;
      instr_valid = 1'b1;
      while (instr_ready !== 1'b1) @(negedge clk_a);  // Held while out of credits.
      @(posedge clk_a);
      model_issue(i, imm);
      @(negedge clk_a);
      instr_valid = 1'b0;
   endtask

   always @(negedge clk_a)
   begin
      if (reset === 1'b0)
      begin
         if (result_valid === 1'b1)
         begin
            if (exp_addr_q.size() == 0)
            begin
               $display("Unexpected result at addr %0d with no instruction pending",
                        result_addr);
               $display("TEST FAILED");
               $fatal(1, "unexpected result");
            end
            check_result(exp_name_q.pop_front(), exp_addr_q.pop_front(),
                         exp_data_q.pop_front(), result_addr, result_data);
         end
         if (illegal_op === 1'b1)
            illegal_seen++;
         if (instr_ready === 1'b0)
            ready_dropped = 1'b1;
      end
   end

   initial
   begin
      wait (table_len > 0);
      #(table_len * 3 * 100 * 2 + 20000);  // Covers random gaps and resets.
      $display("Timeout: the unit stopped producing results");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      reset = 1'b1;
      instr_valid = 1'b0;
      instr_op = '0;
      instr_dst = '0;
      instr_srca = '0;
      instr_srcb = '0;
      instr_imm = '0;
      seed = $urandom(32'ha65b);
      for (int w = 0; w < (1 << `MMEM_AW); w++)
         add_entry("load_fill", OP_LOAD, w, 0, 0, '0, 1, 1, 0);
      add_entry("load_a", OP_LOAD, 1, 0, 0, 32'h5, 0, 1, 0);
      add_entry("load_b", OP_LOAD, 2, 0, 0, 32'h7, 0, 1, 0);
      add_entry("sub_wrap", OP_SUB, 10, 1, 2, '0, 0, 1, 0);
      add_entry("add", OP_ADD, 11, 1, 2, '0, 0, 1, 0);
      add_entry("and", OP_AND, 12, 20, 21, '0, 0, 1, 0);
      add_entry("or", OP_OR, 13, 22, 23, '0, 0, 1, 0);
      add_entry("xor_same", OP_XOR, 14, 5, 5, '0, 0, 1, 0);
      add_entry("sub_same", OP_SUB, 15, 6, 6, '0, 0, 1, 0);
      add_entry("add_same", OP_ADD, 16, 30, 30, '0, 0, 1, 0);
      add_entry("dep_add", OP_ADD, 17, 1, 2, '0, 0, 0, 0);
      add_entry("dep_sub", OP_SUB, 18, 17, 1, '0, 0, 0, 0);
      add_entry("dep_xor", OP_XOR, 19, 18, 17, '0, 0, 0, 0);
      add_entry("dep_or", OP_OR, 20, 19, 3, '0, 0, 0, 0);
      add_entry("illegal_6", 3'd6, 9, 1, 2, 32'hdead, 0, 1, 0);
      add_entry("illegal_7", 3'd7, 9, 1, 2, 32'hbeef, 0, 1, 0);
      add_entry("readback_9", OP_OR, 9, 9, 9, '0, 0, 1, 0);
      for (int k = 0; k < 8; k++)
         add_entry("burst", (k % 2 == 0) ? OP_ADD : OP_XOR, 24 + k, 23 + k, k, '0, 0, 0, 0);
      add_entry("reset_keep_24", OP_OR, 24, 24, 24, '0, 0, 1, 1);
      add_entry("reset_keep_9", OP_OR, 9, 9, 9, '0, 0, 1, 0);
      add_entry("after_reset_add", OP_ADD, 8, 24, 31, '0, 0, 1, 0);
      table_len = name_t.size();
      apply_reset();
      for (int i = 0; i < table_len; i++)
         run_entry(i);
      wait_drain();
      check_illegal("illegal_total", illegal_exp, illegal_seen);
      check_flag("burst_ready_drop", 1'b1, ready_dropped);
      $display("TEST PASSED");
      $finish;
   end

endmodule
